/* src/capture_pkg.sv */
/* data format of the capture stream: word layout, frame markers and routing selects
   frames are padded to ALIGN_WORDS, which must stay a power of two */
`default_nettype none

package capture_pkg;

  ////////////////////////////////////////////////////////////
  // word geometry
  ////////////////////////////////////////////////////////////

  // one output word, two routed halves
  localparam int WORD_W = 64;
  localparam int HALF_W = 32;

  // single I or Q sample, a half holds {I, Q}
  localparam int IQ_W = 16;

  ////////////////////////////////////////////////////////////
  // frame marking
  ////////////////////////////////////////////////////////////

  // ascii FRST in the low half of the header
  localparam logic [HALF_W-1:0] MARK_FIRST = 32'h4652_5354;
  // ascii LAST in the low half of the trailer
  localparam logic [HALF_W-1:0] MARK_LAST = 32'h4c41_5354;

  // header + data + padding + trailer is a multiple of this
  localparam int ALIGN_WORDS = 64;

  // content of one half word, 2-bit field of the control word
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ     = 2'b00,
    ROUTE_DAC_IQ     = 2'b01,
    ROUTE_SAMPLE_CNT = 2'b10,
    ROUTE_CYCLE_CNT  = 2'b11
  } route_sel_e;

endpackage

`default_nettype wire

/* src/ctrl_pkg.sv */
/* capture control: source select, sequencer states, source latencies and control word
   field positions; latencies are in clk_245_76MHz cycles */
`default_nettype none

package ctrl_pkg;

  // control word width
  localparam int CTRL_W = 32;

  // waveform only when both source bits are set
  typedef enum logic {
    SRC_CHIRP = 1'b0,
    SRC_WFRM  = 1'b1
  } source_e;

  typedef enum logic [2:0] {
    IDLE,
    LEAD_IN,
    ARMED,
    CAPTURE,
    PAD,
    TRAIL
  } seq_state_e;

  ////////////////////////////////////////////////////////////
  // source latency
  ////////////////////////////////////////////////////////////

  localparam int LAT_W = 5;
  // chirp dds, start and end
  localparam logic [LAT_W-1:0] CHIRP_DELAY = 5'd4;
  // stored waveform, start
  localparam logic [LAT_W-1:0] WFRM_DELAY = 5'd19;
  // stored waveform, end
  localparam logic [LAT_W-1:0] WFRM_DELAY_END = 5'd2;

  // control word fields, 2 bits each
  localparam int ROUTE_L_LSB = 0;
  localparam int ROUTE_U_LSB = 4;
  localparam int SOURCE_LSB = 8;

endpackage

`default_nettype wire

/* src/capture_if.sv */
/* internal links of the capture core, no clock inside
   stream_word_if has no ready, the sink must absorb every valid word */
`timescale 1ns/1ps
`default_nettype none

// framing control from the sequencer to the router
interface capture_ctrl_if;
  logic capture_en;
  logic frame_first;
  logic frame_last;
  logic pad;
  // router side, high in the cycle a word is requested
  logic word_written;

  modport seq (
    output capture_en,
    output frame_first,
    output frame_last,
    output pad,
    input  word_written
  );

  modport rtr (
    input  capture_en,
    input  frame_first,
    input  frame_last,
    input  pad,
    output word_written
  );
endinterface

// routed words towards the output buffer
interface stream_word_if;
  import capture_pkg::*;

  logic [WORD_W-1:0] data;
  logic              valid;
  // trailer word
  logic              last;

  modport src (output data, output valid, output last);
  modport snk (input data, input valid, input last);
endinterface

`default_nettype wire

/* src/capture_sequencer.sv */
/* frames one capture per chirp_init_i; adc_enable_i must go high after chirp_init_i
   padding only advances on sample_valid_i, so the sample clock must keep running */
`timescale 1ns/1ps
`default_nettype none

module capture_sequencer (
  input  logic                        clk_245_76MHz,
  input  logic                        cpu_reset,
  input  logic                        chirp_init_i,
  input  logic                        chirp_enable_i,
  input  logic                        adc_enable_i,
  input  logic                        sample_valid_i,
  input  logic [ctrl_pkg::CTRL_W-1:0] control_word_i,
  capture_ctrl_if.seq                 ctrl
);
  import ctrl_pkg::*;
  import capture_pkg::*;

  localparam int CNT_W = $clog2(ALIGN_WORDS);

  logic             adc_en_r;
  source_e          source_q;
  logic [LAT_W-1:0] lat_cnt_q;
  seq_state_e       state_q;
  seq_state_e       state_d;
  logic             stop_q;
  logic [CNT_W-1:0] word_cnt_q;
  logic             en_fall;
  logic             lat_zero;
  logic             pad_done;
  logic             pad_last;

  ////////////////////////////////////////////////////////////
  // enable and source
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      adc_en_r <= 1'b0;
      source_q <= SRC_CHIRP;
    end else begin
      adc_en_r <= adc_enable_i;
      // source only changes while the chirp is off
      if (!chirp_enable_i) begin
        source_q <= (&control_word_i[SOURCE_LSB +: 2]) ? SRC_WFRM : SRC_CHIRP;
      end
    end
  end

  // registered enable drops at this edge
  assign en_fall  = (state_q == CAPTURE) && !stop_q && adc_en_r && !adc_enable_i;
  assign lat_zero = (lat_cnt_q == '0);

  ////////////////////////////////////////////////////////////
  // lead-in / lead-out latency
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      lat_cnt_q <= '0;
    end else if ((state_q == IDLE) && chirp_init_i) begin
      lat_cnt_q <= (source_q == SRC_WFRM) ? WFRM_DELAY : CHIRP_DELAY;
    end else if (en_fall) begin
      // samples still in flight from the source
      lat_cnt_q <= (source_q == SRC_WFRM) ? WFRM_DELAY_END : CHIRP_DELAY;
    end else if (!lat_zero) begin
      lat_cnt_q <= lat_cnt_q - 1'b1;
    end
  end

  // words of the current frame, modulo ALIGN_WORDS
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      word_cnt_q <= '0;
    end else if (ctrl.word_written) begin
      // header is word one
      word_cnt_q <= ctrl.frame_first ? CNT_W'(1) : word_cnt_q + 1'b1;
    end
  end

  // trailer fits once the count is one short of alignment
  assign pad_done = (word_cnt_q == CNT_W'(ALIGN_WORDS - 1));
  assign pad_last = (word_cnt_q == CNT_W'(ALIGN_WORDS - 2)) && sample_valid_i;

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state_q <= IDLE;
      stop_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (en_fall) begin
        stop_q <= 1'b1;
      end else if (state_q != CAPTURE) begin
        stop_q <= 1'b0;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (chirp_init_i) begin
          state_d = LEAD_IN;
        end
      end
      LEAD_IN: begin
        if (lat_zero) begin
          state_d = ARMED;
        end
      end
      // header goes out as soon as enable is seen
      ARMED: begin
        if (adc_en_r) begin
          state_d = CAPTURE;
        end
      end
      CAPTURE: begin
        if (stop_q && lat_zero) begin
          state_d = PAD;
        end
      end
      PAD: begin
        if (pad_done || pad_last) begin
          state_d = TRAIL;
        end
      end
      TRAIL: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // requests to the router
  assign ctrl.frame_first = (state_q == ARMED) && adc_en_r;
  assign ctrl.capture_en  = (state_q == CAPTURE) || ((state_q == PAD) && !pad_done);
  assign ctrl.pad         = (state_q == PAD);
  assign ctrl.frame_last  = (state_q == TRAIL);

endmodule

`default_nettype wire

/* src/word_router.sv */
/* route selects follow the control word one cycle late, change them between frames
   sample counter holds real samples only, padding words do not advance it */
`timescale 1ns/1ps
`default_nettype none

module word_router (
  input  logic                          clk_245_76MHz,
  input  logic                          cpu_reset,
  input  logic [capture_pkg::IQ_W-1:0]  adc_i_i,
  input  logic [capture_pkg::IQ_W-1:0]  adc_q_i,
  input  logic [capture_pkg::IQ_W-1:0]  dac_i_i,
  input  logic [capture_pkg::IQ_W-1:0]  dac_q_i,
  input  logic                          sample_valid_i,
  input  logic [ctrl_pkg::CTRL_W-1:0]   control_word_i,
  capture_ctrl_if.rtr                   ctrl,
  stream_word_if.src                    wr
);
  import capture_pkg::*;
  import ctrl_pkg::*;

  route_sel_e        route_u_q;
  route_sel_e        route_l_q;
  logic [HALF_W-1:0] sample_cnt_q;
  logic [HALF_W-1:0] cycle_cnt_q;
  logic [HALF_W-1:0] upper_half;
  logic [HALF_W-1:0] lower_half;
  logic              sample_take;

  // one routed half
  function automatic logic [HALF_W-1:0] pick_half(input route_sel_e sel,
                                                  input logic [HALF_W-1:0] adc_iq,
                                                  input logic [HALF_W-1:0] dac_iq,
                                                  input logic [HALF_W-1:0] smp_cnt,
                                                  input logic [HALF_W-1:0] cyc_cnt);
    logic [HALF_W-1:0] half;
    unique case (sel)
      ROUTE_ADC_IQ:     half = adc_iq;
      ROUTE_DAC_IQ:     half = dac_iq;
      ROUTE_SAMPLE_CNT: half = smp_cnt;
      default:          half = cyc_cnt;
    endcase
    return half;
  endfunction

  assign upper_half = pick_half(route_u_q, {adc_i_i, adc_q_i}, {dac_i_i, dac_q_i},
                                sample_cnt_q, cycle_cnt_q);
  assign lower_half = pick_half(route_l_q, {adc_i_i, adc_q_i}, {dac_i_i, dac_q_i},
                                sample_cnt_q, cycle_cnt_q);

  // header, trailer or one word per valid sample
  assign ctrl.word_written = ctrl.frame_first || ctrl.frame_last
                             || (ctrl.capture_en && sample_valid_i);
  assign sample_take = ctrl.capture_en && sample_valid_i && !ctrl.pad;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_u_q    <= ROUTE_ADC_IQ;
      route_l_q    <= ROUTE_ADC_IQ;
      sample_cnt_q <= '0;
      cycle_cnt_q  <= '0;
      wr.valid     <= 1'b0;
      wr.last      <= 1'b0;
    end else begin
      route_u_q   <= route_sel_e'(control_word_i[ROUTE_U_LSB +: 2]);
      route_l_q   <= route_sel_e'(control_word_i[ROUTE_L_LSB +: 2]);
      cycle_cnt_q <= cycle_cnt_q + 1'b1;
      if (sample_take) begin
        sample_cnt_q <= sample_cnt_q + 1'b1;
      end
      wr.valid <= ctrl.word_written;
      wr.last  <= ctrl.frame_last;
    end
  end

  // markers sit in the low half, cycle count above
  always_ff @(posedge clk_245_76MHz) begin
    if (ctrl.frame_first) begin
      wr.data <= {cycle_cnt_q, MARK_FIRST};
    end else if (ctrl.frame_last) begin
      wr.data <= {cycle_cnt_q, MARK_LAST};
    end else begin
      wr.data <= {upper_half, lower_half};
    end
  end

endmodule

`default_nettype wire

/* src/credit_fifo.sv */
/* FIFO_DEPTH must be a power of two and hold a whole frame, extra words are dropped
   one word leaves per cycle while credits remain, at most CREDIT_MAX outstanding */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter int FIFO_DEPTH = 128,
  parameter int CREDIT_MAX = 8
) (
  input  logic                            clk_245_76MHz,
  input  logic                            cpu_reset,
  stream_word_if.snk                      wr,
  input  logic                            credit_return_i,
  output logic [capture_pkg::WORD_W-1:0]  m_tdata_o,
  output logic                            m_tvalid_o,
  output logic                            m_tlast_o,
  output logic                            overflow_o
);
  import capture_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(CREDIT_MAX + 1);

  // {last, data}
  logic [WORD_W:0] mem_q [FIFO_DEPTH];
  logic [AW-1:0]   wr_ptr_q;
  logic [AW-1:0]   rd_ptr_q;
  logic [AW:0]     fill_q;
  logic [CW-1:0]   credit_q;
  logic            full;
  logic            empty;
  logic            push;
  logic            pop;

  assign full  = (fill_q == (AW + 1)'(FIFO_DEPTH));
  assign empty = (fill_q == '0);
  assign push  = wr.valid && !full;
  assign pop   = !empty && (credit_q != '0);

  ////////////////////////////////////////////////////////////
  // storage and output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {wr.last, wr.data};
    end
    if (pop) begin
      m_tdata_o <= mem_q[rd_ptr_q][WORD_W-1:0];
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      m_tvalid_o <= 1'b0;
      m_tlast_o  <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + (AW + 1)'(push) - (AW + 1)'(pop);
      // single-cycle pulse per word
      m_tvalid_o <= pop;
      m_tlast_o  <= pop && mem_q[rd_ptr_q][WORD_W];
      // sticky, a word was lost
      if (wr.valid && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // credits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      credit_q <= CW'(CREDIT_MAX);
    end else begin
      unique case ({pop, credit_return_i})
        2'b10: credit_q <= credit_q - 1'b1;
        2'b01: begin
          // saturate, surplus returns are ignored
          if (credit_q != CW'(CREDIT_MAX)) begin
            credit_q <= credit_q + 1'b1;
          end
        end
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/adc_capture_top.sv */
/* single clock capture framing core, plain ports only
   output has no ready, the consumer paces it with credit_return_i */
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top #(
  parameter int FIFO_DEPTH = 128,
  parameter int CREDIT_MAX = 8
) (
  input  logic                            clk_245_76MHz,
  input  logic                            cpu_reset,
  // capture control
  input  logic                            chirp_init_i,
  input  logic                            chirp_enable_i,
  input  logic                            adc_enable_i,
  input  logic [ctrl_pkg::CTRL_W-1:0]     control_word_i,
  // sample inputs
  input  logic                            sample_valid_i,
  input  logic [capture_pkg::IQ_W-1:0]    adc_i_i,
  input  logic [capture_pkg::IQ_W-1:0]    adc_q_i,
  input  logic [capture_pkg::IQ_W-1:0]    dac_i_i,
  input  logic [capture_pkg::IQ_W-1:0]    dac_q_i,
  // output stream
  input  logic                            credit_return_i,
  output logic [capture_pkg::WORD_W-1:0]  m_tdata_o,
  output logic                            m_tvalid_o,
  output logic                            m_tlast_o,
  output logic                            overflow_o
);

  capture_ctrl_if u_ctrl_if ();
  stream_word_if  u_stream_if ();

  // framing control
  capture_sequencer u_capture_sequencer (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .adc_enable_i   (adc_enable_i),
    .sample_valid_i (sample_valid_i),
    .control_word_i (control_word_i),
    .ctrl           (u_ctrl_if.seq)
  );

  // word assembly
  word_router u_word_router (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .adc_i_i        (adc_i_i),
    .adc_q_i        (adc_q_i),
    .dac_i_i        (dac_i_i),
    .dac_q_i        (dac_q_i),
    .sample_valid_i (sample_valid_i),
    .control_word_i (control_word_i),
    .ctrl           (u_ctrl_if.rtr),
    .wr             (u_stream_if.src)
  );

  // buffer and credit gate
  credit_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CREDIT_MAX (CREDIT_MAX)
  ) u_credit_fifo (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .wr              (u_stream_if.snk),
    .credit_return_i (credit_return_i),
    .m_tdata_o       (m_tdata_o),
    .m_tvalid_o      (m_tvalid_o),
    .m_tlast_o       (m_tlast_o),
    .overflow_o      (overflow_o)
  );

endmodule

`default_nettype wire

/* sim/tb_adc_capture_chk.sv */
/* bound onto adc_capture_top, watches the output stream only
   needs u_credit_fifo.credit_q inside the top level */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture_chk (
  input logic clk_245_76MHz,
  input logic cpu_reset,
  input logic credit_zero_i,
  input logic m_tvalid_i,
  input logic m_tlast_i,
  input logic overflow_i
);

  // no credit held, so nothing may leave next cycle
  property no_word_without_credit;
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      credit_zero_i |=> !m_tvalid_i;
  endproperty

  // buffer must absorb every frame
  property no_overflow;
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      !overflow_i;
  endproperty

  property last_with_valid;
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      m_tlast_i |-> m_tvalid_i;
  endproperty

  a_credit : assert property (no_word_without_credit)
    else $error("word presented with no credit held");
  a_overflow : assert property (no_overflow)
    else $error("output buffer overflowed");
  a_last : assert property (last_with_valid)
    else $error("m_tlast_o high without m_tvalid_o");

endmodule

bind adc_capture_top tb_adc_capture_chk u_capture_chk (
  .clk_245_76MHz (clk_245_76MHz),
  .cpu_reset     (cpu_reset),
  .credit_zero_i (u_credit_fifo.credit_q == '0),
  .m_tvalid_i    (m_tvalid_o),
  .m_tlast_i     (m_tlast_o),
  .overflow_i    (overflow_o)
);

`default_nettype wire

/* sim/tb_adc_capture.sv */
/* reads sim/capture_input.txt, so run from the project root
   latency checks are relative to the first chirp test, which must come first */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture;
  import capture_pkg::*;
  import ctrl_pkg::*;

  localparam int HDR_TIMEOUT   = 200;
  localparam int FRAME_TIMEOUT = 4000;

  logic                 clk_245_76MHz;
  logic                 cpu_reset;
  logic                 chirp_init_i;
  logic                 chirp_enable_i;
  logic                 adc_enable_i;
  logic [CTRL_W-1:0]    control_word_i;
  logic                 sample_valid_i;
  logic [IQ_W-1:0]      adc_i_i;
  logic [IQ_W-1:0]      adc_q_i;
  logic [IQ_W-1:0]      dac_i_i;
  logic [IQ_W-1:0]      dac_q_i;
  logic                 credit_return_i = 1'b0;
  logic [WORD_W-1:0]    m_tdata_o;
  logic                 m_tvalid_o;
  logic                 m_tlast_o;
  logic                 overflow_o;

  // collected output and the cycle each word arrived
  logic [WORD_W-1:0]    word_q[$];
  logic                 last_q[$];
  int                   when_q[$];
  int                   cycle_cnt = 0;
  int                   stall_until = 0;
  int                   stall_words = 0;
  logic                 stall_prev = 1'b0;
  logic [7:0]           credit_pat = 8'hff;
  logic [31:0]          lfsr_q = 32'hf722_4f04;
  logic [HALF_W-1:0]    sample_total = '0;
  int                   chirp_lat = -1;
  int                   test_errs;
  logic                 stop;
  string                why;

  adc_capture_top u_adc_capture_top (.*);

  initial begin
    clk_245_76MHz = 1'b0;
    forever #2 clk_245_76MHz = ~clk_245_76MHz;
  end

  ////////////////////////////////////////////////////////////
  // collector and credit return
  ////////////////////////////////////////////////////////////

  always @(posedge clk_245_76MHz) begin
    cycle_cnt <= cycle_cnt + 1;
    stall_prev <= (cycle_cnt < stall_until);
    if (!cpu_reset && m_tvalid_o) begin
      word_q.push_back(m_tdata_o);
      last_q.push_back(m_tlast_o);
      when_q.push_back(cycle_cnt);
      // words granted while returns were held
      if (stall_prev) begin
        stall_words <= stall_words + 1;
      end
    end
  end

  always @(negedge clk_245_76MHz) begin
    if (cycle_cnt < stall_until) begin
      credit_return_i <= 1'b0;
    end else begin
      credit_return_i <= credit_pat[cycle_cnt % 8];
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [IQ_W-1:0] rand_iq();
    logic [IQ_W-1:0] val;
    logic            fb;
    val = '0;
    for (int b = 0; b < IQ_W; b++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val = {val[IQ_W-2:0], fb};
    end
    return val;
  endfunction

  // half word content expected for a route select
  function automatic logic [HALF_W-1:0] expected_half(input int route,
                                                      input logic [HALF_W-1:0] adc,
                                                      input logic [HALF_W-1:0] dac,
                                                      input logic [HALF_W-1:0] cnt);
    if (route == 0) begin
      return adc;
    end else if (route == 1) begin
      return dac;
    end
    return cnt;
  endfunction

  task automatic report_value(input string name, input string what,
                              input logic [63:0] exp_v, input logic [63:0] act_v);
    $display("FAILED %s %s expected %h actual %h", name, what, exp_v, act_v);
    test_errs++;
  endtask

  ////////////////////////////////////////////////////////////
  // one capture frame
  ////////////////////////////////////////////////////////////

  task automatic run_test(input string name, input int ru, input int rl, input int src,
                          input int nsmp, input logic [7:0] pat, input int stall);
    logic [HALF_W-1:0] adc_exp[$];
    logic [HALF_W-1:0] dac_exp[$];
    logic [HALF_W-1:0] cnt_base;
    logic [WORD_W-1:0] w;
    int                start;
    int                t0;
    int                waited;
    int                end_idx;
    int                scan;
    int                len;
    int                lat;
    int                exp_lat;
    int                stall_base;
    test_errs = 0;
    credit_pat <= 8'hff;
    chirp_enable_i = 1'b0;
    control_word_i = '0;
    control_word_i[ROUTE_U_LSB +: 2] = 2'(ru);
    control_word_i[ROUTE_L_LSB +: 2] = 2'(rl);
    control_word_i[SOURCE_LSB +: 2] = (src == 1) ? 2'b11 : 2'b00;
    // credits refill, source latches
    repeat (20) @(negedge clk_245_76MHz);
    chirp_enable_i = 1'b1;
    @(negedge clk_245_76MHz);
    if (src == 2) begin
      control_word_i[SOURCE_LSB +: 2] = 2'b11;
    end
    repeat (2) @(negedge clk_245_76MHz);
    credit_pat <= pat;
    start = word_q.size();
    cnt_base = sample_total;
    chirp_init_i = 1'b1;
    t0 = cycle_cnt;
    @(negedge clk_245_76MHz);
    chirp_init_i = 1'b0;
    adc_enable_i = 1'b1;
    waited = 0;
    while (word_q.size() == start && waited < HDR_TIMEOUT) begin
      waited++;
      @(negedge clk_245_76MHz);
    end
    if (word_q.size() == start) begin
      why = {"timeout waiting for the header of ", name};
      stop = 1'b1;
      return;
    end
    stall_base = stall_words;
    if (stall > 0) begin
      stall_until <= cycle_cnt + stall;
    end
    for (int k = 0; k < nsmp; k++) begin
      adc_i_i = rand_iq();
      adc_q_i = rand_iq();
      dac_i_i = rand_iq();
      dac_q_i = rand_iq();
      sample_valid_i = 1'b1;
      adc_exp.push_back({adc_i_i, adc_q_i});
      dac_exp.push_back({dac_i_i, dac_q_i});
      @(negedge clk_245_76MHz);
    end
    sample_valid_i = 1'b0;
    adc_enable_i = 1'b0;
    sample_total = sample_total + HALF_W'(nsmp);
    // let the lead-out drain before padding samples run
    repeat (8) @(negedge clk_245_76MHz);
    sample_valid_i = 1'b1;
    end_idx = -1;
    scan = start;
    waited = 0;
    while (end_idx < 0 && waited < FRAME_TIMEOUT) begin
      while (scan < word_q.size() && end_idx < 0) begin
        if (last_q[scan]) begin
          end_idx = scan;
        end
        scan++;
      end
      waited++;
      @(negedge clk_245_76MHz);
    end
    sample_valid_i = 1'b0;
    if (end_idx < 0) begin
      why = {"timeout waiting for the trailer of ", name};
      stop = 1'b1;
      return;
    end

    len = end_idx - start + 1;
    if (word_q[start][HALF_W-1:0] != MARK_FIRST) begin
      report_value(name, "header marker", 64'(MARK_FIRST), 64'(word_q[start][HALF_W-1:0]));
    end
    if (word_q[end_idx][HALF_W-1:0] != MARK_LAST) begin
      report_value(name, "trailer marker", 64'(MARK_LAST), 64'(word_q[end_idx][HALF_W-1:0]));
    end
    if (word_q[end_idx][WORD_W-1:HALF_W] <= word_q[start][WORD_W-1:HALF_W]) begin
      $display("%s trailer cycle count is not above the header's", name);
      test_errs++;
    end
    if ((len % ALIGN_WORDS) != 0 || len < nsmp + 2) begin
      $display("%s frame length %0d is not a full multiple of %0d", name, len, ALIGN_WORDS);
      test_errs++;
    end
    for (int k = start; k < end_idx; k++) begin
      if (last_q[k]) begin
        $display("%s m_tlast_o set before the trailer at word %0d", name, k - start);
        test_errs++;
      end
    end
    // data words follow the header in sample order
    for (int k = 0; k < nsmp && k < len - 2; k++) begin
      w = word_q[start + 1 + k];
      if (ru != 3 && w[WORD_W-1:HALF_W] !=
          expected_half(ru, adc_exp[k], dac_exp[k], cnt_base + HALF_W'(k))) begin
        report_value(name, $sformatf("upper half of sample %0d", k),
                     64'(expected_half(ru, adc_exp[k], dac_exp[k], cnt_base + HALF_W'(k))),
                     64'(w[WORD_W-1:HALF_W]));
      end
      if (rl != 3 && w[HALF_W-1:0] !=
          expected_half(rl, adc_exp[k], dac_exp[k], cnt_base + HALF_W'(k))) begin
        report_value(name, $sformatf("lower half of sample %0d", k),
                     64'(expected_half(rl, adc_exp[k], dac_exp[k], cnt_base + HALF_W'(k))),
                     64'(w[HALF_W-1:0]));
      end
    end
    // lead-in relative to a chirp frame
    lat = when_q[start] - t0;
    if (src == 0 && chirp_lat < 0) begin
      // first chirp frame sets the reference
      chirp_lat = lat;
    end else begin
      exp_lat = chirp_lat + ((src == 1) ? int'(WFRM_DELAY) - int'(CHIRP_DELAY) : 0);
      if (lat != exp_lat) begin
        report_value(name, "header latency", 64'(exp_lat), 64'(lat));
      end
    end
    if (stall > 0 && (stall_words - stall_base) > u_adc_capture_top.CREDIT_MAX) begin
      report_value(name, "words during stall", 64'(u_adc_capture_top.CREDIT_MAX),
                   64'(stall_words - stall_base));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    int          run_cnt;
    int          pass_cnt;
    string       line;
    string       name;
    int          ru;
    int          rl;
    int          src;
    int          nsmp;
    int          stall;
    logic [7:0]  pat;
    cpu_reset = 1'b1;
    chirp_init_i = 1'b0;
    chirp_enable_i = 1'b0;
    adc_enable_i = 1'b0;
    control_word_i = '0;
    sample_valid_i = 1'b0;
    adc_i_i = '0;
    adc_q_i = '0;
    dac_i_i = '0;
    dac_q_i = '0;
    stop = 1'b0;
    why = "";
    run_cnt = 0;
    pass_cnt = 0;
    repeat (4) @(posedge clk_245_76MHz);
    @(negedge clk_245_76MHz);
    cpu_reset = 1'b0;
    fd = $fopen("sim/capture_input.txt", "r");
    if (fd == 0) begin
      why = "cannot open sim/capture_input.txt";
      stop = 1'b1;
    end
    while (!stop && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == 8'h23) begin
        continue;
      end
      n = $sscanf(line, "%s %d %d %d %d %h %d", name, ru, rl, src, nsmp, pat, stall);
      if (n != 7) begin
        why = {"malformed line in input file: ", line};
        stop = 1'b1;
      end else begin
        run_test(name, ru, rl, src, nsmp, pat, stall);
        run_cnt++;
        if (!stop && test_errs == 0) begin
          pass_cnt++;
          $display("PASS %s", name);
        end else if (!stop) begin
          $display("FAIL %s with %0d errors", name, test_errs);
        end
      end
    end
    if (stop) begin
      $display("%s", why);
    end
    $display("tests run %0d, passed %0d, failed %0d", run_cnt, pass_cnt, run_cnt - pass_cnt);
    if (stop || pass_cnt != run_cnt || run_cnt == 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/capture_pkg.sv
src/ctrl_pkg.sv
src/capture_if.sv
src/capture_sequencer.sv
src/word_router.sv
src/credit_fifo.sv
src/adc_capture_top.sv
sim/tb_adc_capture_chk.sv
sim/tb_adc_capture.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator from the project root.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
  --top-module tb_adc_capture \
  -f verilog.f \
  -o Vtb_adc_capture

./obj_dir/Vtb_adc_capture | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: failure reported in sim.log"
  exit 1
fi
echo "run_sim: done"

/* sim/capture_input.txt */
# name route_u route_l source samples credit_pattern(hex, bit per cycle) stall_cycles
# route 0 adc_iq 1 dac_iq 2 sample_cnt 3 cycle_cnt; source 0 chirp 1 wfrm 2 wfrm set while chirp on
frame_chirp 0 1 0 1 ff 0
align_63 0 1 0 63 ff 0
align_100 0 1 0 100 ff 0
smp_cnt_a 2 0 0 10 ff 0
smp_cnt_b 2 0 0 20 55 0
src_wfrm 0 1 1 5 ff 0
src_locked 0 1 2 5 ff 0
stall_63 0 1 0 63 ff 40
